// File: design/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	localparam int WORD_W = 32;                       // Datapath width.
	localparam int REG_W = 5;                         // Register index width.
	localparam int MEM_WAIT = 3;                      // Cycles a memory access holds MEM.
	localparam int DMEM_WORDS = 64;                   // Data RAM depth.
	localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);  // Word index width.
	localparam int TIMER_W = $clog2(MEM_WAIT + 1);    // Wait counter width.

	typedef logic [WORD_W-1:0] word_t;                // Operands, results, memory data.
	typedef logic [REG_W-1:0] regbits_t;              // Register number.

	// ALU function select, eight codes fill the 3-bit field.
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,                               // a + b.
		ALU_SUB = 3'd1,                               // a - b.
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,                               // Signed compare.
		ALU_SLL = 3'd6,                               // Shift by b[4:0].
		ALU_SRL = 3'd7                                // Logical right shift.
	} aluop_t;

	typedef enum logic {
		SEL_RD = 1'b0,                                // R-type destination.
		SEL_RT = 1'b1                                 // I-type destination.
	} reg_dest_t;

	typedef struct packed {
		logic     valid;                              // Slot holds an instruction.
		logic     wen;                                // Register write requested.
		logic     dren;                               // Load.
		logic     dwen;                               // Store.
		regbits_t dest;                               // Writeback register.
		word_t    result;                             // ALU result, also memory address.
		word_t    store_data;                         // Data for a store.
	} ex_mem_t;

	typedef struct packed {
		logic     valid;                              // Writeback strobe.
		logic     wen;                                // Register file write.
		regbits_t dest;
		word_t    data;                               // Load data or ALU result.
	} mem_wb_t;

endpackage

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit import cpu_types_pkg::*; (
	input  aluop_t    alu_op,
	input  word_t     opa,
	input  word_t     opb,
	input  word_t     store_data,
	input  regbits_t  rt,
	input  regbits_t  rd,
	input  reg_dest_t reg_dest,
	input  logic      wen,
	input  logic      dren,
	input  logic      dwen,
	input  logic      in_valid,
	output ex_mem_t   ex_out
);

	word_t result;                                       // ALU output.
	logic  slt_bit;                                      // Signed less-than flag.

	assign slt_bit = $signed(opa) < $signed(opb);

	always_comb begin
		case (alu_op)
			ALU_ADD: result = opa + opb;
			ALU_SUB: result = opa - opb;
			ALU_AND: result = opa & opb;
			ALU_OR:  result = opa | opb;
			ALU_XOR: result = opa ^ opb;
			ALU_SLT: result = {{(WORD_W-1){1'b0}}, slt_bit}; // Zero-extended flag.
			ALU_SLL: result = opa << opb[4:0];
			ALU_SRL: result = opa >> opb[4:0];
			default: result = '0;
		endcase
	end

	// Bubble slots carry no control, so later stages see a clean zero.
	assign ex_out.valid = in_valid;
	assign ex_out.wen = wen & in_valid;
	assign ex_out.dren = dren & in_valid;
	assign ex_out.dwen = dwen & in_valid;
	assign ex_out.dest = (reg_dest == SEL_RT) ? rt : rd; // Destination pick.
	assign ex_out.result = result;                       // Address for loads and stores.
	assign ex_out.store_data = store_data;

endmodule

`default_nettype wire

// File: design/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic                      // Stage payload struct.
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     enable,                              // Load d this cycle.
	input  logic     flush,                               // Replace with bubble.
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			q <= '0;                                      // Empty stage.
		end
		else if (flush) begin
			q <= '0;                                      // Flush beats enable.
		end
		else if (enable) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: design/wait_timer.sv
`timescale 1ns/100ps
`default_nettype none

module wait_timer import cpu_types_pkg::*; (
	input  logic CLK,
	input  logic nRST,
	input  logic start,                                   // Begin a new wait.
	output logic done                                     // Last cycle of the wait.
);

	logic [TIMER_W-1:0] count;                            // Cycles left.
	logic               running;                          // Wait in progress.

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			count <= '0;
			running <= 1'b0;
		end
		else if (start) begin
			count <= TIMER_W'(MEM_WAIT - 1);               // A restart wins over a stale wait.
			running <= 1'b1;
		end
		else if (running) begin
			if (count == '0)
				running <= 1'b0;                          // Expired, done drops.
			else
				count <= count - 1'b1;
		end
	end

	assign done = running && (count == '0);               // One cycle only.

endmodule

`default_nettype wire

// File: design/mem_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm (
	input  logic CLK,
	input  logic nRST,
	input  logic mem_req,                                 // EX/MEM holds a load or store.
	input  logic item_valid,                              // EX/MEM holds anything.
	input  logic flush,
	input  logic timer_done,
	output logic timer_start,
	output logic ex_mem_enable,
	output logic mem_wb_enable,
	output logic mem_write_en,                            // RAM write, store filtered downstream.
	output logic busy                                     // Upstream must hold issue.
);

	typedef enum logic {
		IDLE   = 1'b0,
		ACCESS = 1'b1
	} state_t;

	state_t state, next_state;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;                               // Defaults.
		timer_start = 1'b0;
		ex_mem_enable = 1'b1;
		mem_wb_enable = 1'b0;
		mem_write_en = 1'b0;
		busy = 1'b0;
		case (state)
			IDLE: begin
				busy = mem_req;                           // Request blocks issue at once.
				if (flush) begin
					next_state = IDLE;                    // Slot is bubbled, nothing to do.
				end
				else if (mem_req) begin
					timer_start = 1'b1;
					ex_mem_enable = 1'b0;                 // Hold the access in EX/MEM.
					next_state = ACCESS;
				end
				else begin
					mem_wb_enable = item_valid;           // ALU item passes straight on.
				end
			end
			ACCESS: begin
				busy = ~timer_done;                       // Free on the last wait cycle.
				ex_mem_enable = timer_done;
				if (flush) begin
					next_state = IDLE;                    // Access abandoned, no write.
				end
				else if (timer_done) begin
					mem_wb_enable = 1'b1;
					mem_write_en = 1'b1;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: design/data_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem_stage import cpu_types_pkg::*; (
	input  logic    CLK,
	input  logic    nRST,
	input  logic    write_en,                             // Last cycle of an access.
	input  ex_mem_t ex_in,
	output mem_wb_t wb_out
);

	word_t                  ram [DMEM_WORDS];             // Data memory.
	logic [DMEM_ADDR_W-1:0] index;                        // Word address.
	word_t                  rdata;

	assign index = ex_in.result[DMEM_ADDR_W+1:2];         // Byte address to word.
	assign rdata = ram[index];                            // Asynchronous read.

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				ram[i] <= '0;                             // Memory reads zero after reset.
		end
		else if (write_en && ex_in.dwen) begin
			ram[index] <= ex_in.store_data;
		end
	end

	assign wb_out.valid = ex_in.valid;
	assign wb_out.wen = ex_in.wen & ~ex_in.dwen;          // Stores never write a register.
	assign wb_out.dest = ex_in.dest;
	assign wb_out.data = ex_in.dren ? rdata : ex_in.result;

endmodule

`default_nettype wire

// File: design/ex_mem_wb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_wb import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  logic      in_valid,                           // Issue strobe.
	input  aluop_t    alu_op,
	input  word_t     opa,
	input  word_t     opb,
	input  word_t     store_data,
	input  regbits_t  rt,
	input  regbits_t  rd,
	input  reg_dest_t reg_dest,
	input  logic      wen,
	input  logic      dren,
	input  logic      dwen,
	input  logic      flush,                              // Kills the EX/MEM slot.
	output logic      busy,
	output logic      wb_valid,
	output logic      wb_wen,
	output regbits_t  wb_dest,
	output word_t     wb_data
);

	ex_mem_t ex_d, ex_q;                                  // EX/MEM in and out.
	mem_wb_t wb_d, wb_q;                                  // MEM/WB in and out.
	logic    ex_mem_enable;
	logic    mem_wb_enable;
	logic    mem_wb_clear;                                // Bubble when not loading.
	logic    mem_req;
	logic    item_valid;
	logic    timer_start;
	logic    timer_done;
	logic    mem_write_en;

	assign item_valid = ex_q.valid;
	assign mem_req = ex_q.valid & (ex_q.dren | ex_q.dwen);
	assign mem_wb_clear = ~mem_wb_enable;                 // Writeback stays a one-cycle strobe.

	execute_unit execute_unit_i (
		.alu_op, .opa, .opb, .store_data, .rt, .rd, .reg_dest,
		.wen, .dren, .dwen, .in_valid,
		.ex_out (ex_d)
	);

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
		.CLK, .nRST,
		.enable (ex_mem_enable),
		.flush  (flush),
		.d      (ex_d),
		.q      (ex_q)
	);

	mem_access_fsm mem_access_fsm_i (
		.CLK, .nRST, .mem_req, .item_valid, .flush, .timer_done,
		.timer_start, .ex_mem_enable, .mem_wb_enable, .mem_write_en, .busy
	);

	wait_timer wait_timer_i (
		.CLK, .nRST,
		.start (timer_start),
		.done  (timer_done)
	);

	data_mem_stage data_mem_stage_i (
		.CLK, .nRST,
		.write_en (mem_write_en),
		.ex_in    (ex_q),
		.wb_out   (wb_d)
	);

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg_i (
		.CLK, .nRST,
		.enable (mem_wb_enable),
		.flush  (mem_wb_clear),
		.d      (wb_d),
		.q      (wb_q)
	);

	assign wb_valid = wb_q.valid;                         // Writeback breakout.
	assign wb_wen = wb_q.wen;
	assign wb_dest = wb_q.dest;
	assign wb_data = wb_q.data;

endmodule

`default_nettype wire

// File: testbench/ex_mem_wb_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_wb_asserts import cpu_types_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic in_valid,                                 // Issue strobe.
	input logic busy,                                     // Memory stall.
	input logic mem_req,                                  // EX/MEM holds a load or store.
	input logic mem_wb_enable,                            // MEM/WB loads this cycle.
	input logic wb_valid                                  // Writeback strobe.
);

	int busy_run;                                         // Busy cycles so far in this stall.
	int fail_count = 0;                                   // Failed protocol checks.

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			busy_run <= 0;
		else
			busy_run <= busy ? busy_run + 1 : 0;
	end

	stall_length: assert property (@(posedge CLK) disable iff (!nRST)
		busy |-> busy_run < MEM_WAIT)
		else begin
			fail_count++;
			$error("busy held for more than %0d cycles", MEM_WAIT);
		end

	no_issue_when_busy: assert property (@(posedge CLK) disable iff (!nRST)
		!(in_valid && busy))
		else begin
			fail_count++;
			$error("in_valid pulsed while busy was high");
		end

	// Finished access with nothing issued behind it gives a one-cycle strobe.
	single_mem_writeback: assert property (@(posedge CLK) disable iff (!nRST)
		$past(mem_req && mem_wb_enable && !in_valid, 2) |-> $past(wb_valid) && !wb_valid)
		else begin
			fail_count++;
			$error("wb_valid high two cycles running after a memory access");
		end

endmodule

bind ex_mem_wb ex_mem_wb_asserts asserts_i (
	.CLK, .nRST, .in_valid, .busy, .mem_req, .mem_wb_enable, .wb_valid
);

`default_nettype wire

// File: testbench/ex_mem_wb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_wb_tb import cpu_types_pkg::*; ();

	localparam int NUM_RANDOM = 150;
	localparam int NUM_DIRECTED = 14;                     // ALU sweep, memory and flush cases.
	localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * (MEM_WAIT + 3) + 108;

	typedef struct packed {
		logic [31:0] due;                                 // Cycle of the writeback.
		logic        wen;
		regbits_t    dest;
		word_t       data;
	} wb_exp_t;

	logic      CLK, nRST, in_valid, wen, dren, dwen, flush;
	aluop_t    alu_op;
	word_t     opa, opb, store_data;
	regbits_t  rt, rd;
	reg_dest_t reg_dest;
	logic      busy, wb_valid, wb_wen;
	regbits_t  wb_dest;
	word_t     wb_data;
	int        cyc = 0;                                   // Rising edges seen.
	int        mismatches = 0;
	int        other_errors = 0;
	wb_exp_t   exp_q[$];                                  // Writebacks still to come.
	word_t     model_mem [DMEM_WORDS];                    // Reference data memory.

	ex_mem_wb dut_i (.*);

	always #20 CLK = ~CLK;                                // 40 ns period.

	always @(posedge CLK) cyc <= cyc + 1;

	initial begin
		while (cyc < TIMEOUT_CYCLES)
			@(posedge CLK);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	function automatic word_t alu_model(input aluop_t op, input word_t a, input word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLL: return a << b[4:0];
			default: return a >> b[4:0];                  // ALU_SRL.
		endcase
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t want);
		mismatches++;
		$display("Mismatch %s: got %h expected %h", name, got, want);
	endtask

	// Called at a drive point; flush_at > 0 kills the item that many cycles later.
	task automatic issue_instr(input aluop_t op, input word_t a, input word_t b,
			input word_t sdata, input regbits_t t, input regbits_t d, input reg_dest_t sel,
			input logic we, input logic rd_mem, input logic wr_mem, input int flush_at);
		wb_exp_t entry;
		word_t   result;
		int      busy_len;
		while (busy) begin                                // Honour the stall.
			@(posedge CLK);
			#2;
		end
		alu_op = op;
		{opa, opb, store_data} = {a, b, sdata};
		{rt, rd} = {t, d};
		reg_dest = sel;
		{wen, dren, dwen} = {we, rd_mem, wr_mem};
		in_valid = 1'b1;
		result = alu_model(op, a, b);
		if (flush_at == 0) begin
			entry.due = cyc + 2 + ((rd_mem || wr_mem) ? MEM_WAIT : 0);
			entry.wen = we & ~wr_mem;                     // Stores write no register.
			entry.dest = (sel == SEL_RT) ? t : d;
			entry.data = rd_mem ? model_mem[result[7:2]] : result;
			exp_q.push_back(entry);
			if (wr_mem)
				model_mem[result[7:2]] = sdata;
		end
		@(posedge CLK);
		#2;
		in_valid = 1'b0;
		if (flush_at > 0) begin
			repeat (flush_at - 1) begin
				@(posedge CLK);
				#2;
			end
			flush = 1'b1;                                 // One-cycle kill.
			@(posedge CLK);
			#2;
			flush = 1'b0;
		end
		else if (rd_mem || wr_mem) begin
			busy_len = 0;
			while (busy) begin
				busy_len++;
				@(posedge CLK);
				#2;
			end
			assert (busy_len == MEM_WAIT)
				else report_mismatch("busy length", busy_len, MEM_WAIT);
		end
	endtask

	task automatic random_instr();
		logic [1:0] kind;
		logic [2:0] w;
		word_t      addr;
		word_t      b;
		kind = 2'($urandom_range(3, 0));                  // 0 load, 1 store, else ALU.
		w = 3'($urandom_range(7, 0));                     // Small shared address set.
		addr = ($urandom & 32'hFFFF_FF03) | {27'd0, w, 2'b00};
		b = $urandom;
		if (kind < 2)
			issue_instr(ALU_ADD, addr - b, b, $urandom, 5'($urandom), 5'($urandom),
				reg_dest_t'(1'($urandom)), 1'($urandom), kind == 0, kind == 1, 0);
		else
			issue_instr(aluop_t'(3'($urandom)), $urandom, $urandom, $urandom, 5'($urandom),
				5'($urandom), reg_dest_t'(1'($urandom)), 1'($urandom), 1'b0, 1'b0, 0);
	endtask

	always @(negedge CLK) begin : wb_check
		wb_exp_t got_entry;
		if (nRST && wb_valid) begin
			assert (exp_q.size() > 0) else begin
				other_errors++;
				$display("Unexpected writeback in cycle %0d", cyc);
			end
			if (exp_q.size() > 0) begin
				got_entry = exp_q.pop_front();
				assert (cyc == got_entry.due)
					else report_mismatch("wb_valid cycle", cyc, got_entry.due);
				assert (wb_wen == got_entry.wen)
					else report_mismatch("wb_wen", 32'(wb_wen), 32'(got_entry.wen));
				assert (wb_dest == got_entry.dest)
					else report_mismatch("wb_dest", 32'(wb_dest), 32'(got_entry.dest));
				assert (wb_data == got_entry.data)
					else report_mismatch("wb_data", wb_data, got_entry.data);
			end
		end
		else if (exp_q.size() > 0) begin
			assert (exp_q[0].due > cyc) else begin
				other_errors++;
				$display("No writeback in cycle %0d where one was due", cyc);
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		void'($urandom(93));                              // Fixed seed.
		{CLK, nRST, in_valid, wen, dren, dwen, flush} = '0;
		alu_op = ALU_ADD;
		{opa, opb, store_data} = '0;
		{rt, rd} = '0;
		reg_dest = SEL_RD;
		for (int i = 0; i < DMEM_WORDS; i++)
			model_mem[i] = '0;                            // RAM is clear after reset.
		repeat (8) @(posedge CLK);
		#2 nRST = 1'b1;
		assert (!busy && !wb_valid) else begin
			other_errors++;
			$display("busy or wb_valid high after reset");
		end
		for (int i = 0; i < 8; i++)                       // Every ALU function once.
			issue_instr(aluop_t'(i), $urandom, $urandom, '0, 5'd3, 5'(i + 8),
				reg_dest_t'(i % 2), 1'b1, 1'b0, 1'b0, 0);
		issue_instr(ALU_ADD, 32'hA0, '0, '0, 5'd4, 5'd0, SEL_RT, 1'b1, 1'b1, 1'b0, 0);
		issue_instr(ALU_ADD, 32'h14, '0, 32'h1234_5678, 5'd6, 5'd7, SEL_RT, 1'b1, 1'b0, 1'b1, 0);
		issue_instr(ALU_ADD, 32'h10, 32'h4, '0, 5'd8, 5'd9, SEL_RT, 1'b1, 1'b1, 1'b0, 0);
		@(posedge CLK);                                   // Nothing behind the load.
		#2;
		issue_instr(ALU_OR, 32'h0F0F, 32'hF0F0, '0, 5'd1, 5'd2, SEL_RD, 1'b1, 1'b0, 1'b0, 1);
		issue_instr(ALU_ADD, 32'h14, '0, 32'hDEAD_BEEF, 5'd1, 5'd2, SEL_RD, 1'b0, 1'b0, 1'b1, 2);
		issue_instr(ALU_ADD, 32'h14, '0, '0, 5'd10, 5'd11, SEL_RD, 1'b1, 1'b1, 1'b0, 0);
		repeat (NUM_RANDOM) random_instr();
		while (exp_q.size() > 0)                          // Drain the pipeline.
			@(posedge CLK);
		repeat (4) @(posedge CLK);
		$display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatches, other_errors, dut_i.asserts_i.fail_count);
		if (mismatches + other_errors + dut_i.asserts_i.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: ex_mem_wb.f
design/cpu_types_pkg.sv
design/execute_unit.sv
design/pipe_reg.sv
design/wait_timer.sv
design/mem_access_fsm.sv
design/data_mem_stage.sv
design/ex_mem_wb.sv
testbench/ex_mem_wb_asserts.sv
testbench/ex_mem_wb_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := ex_mem_wb_tb
FILELIST  := ex_mem_wb.f
OBJDIR    := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The simulation passes only if the pass line appears in its output.
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
